//--- sources.f
+incdir+verilog
verilog/kbd_scan_pkg.sv
verilog/kbd_code_pkg.sv
verilog/kbd_row_scan.sv
verilog/kbd_change_detect.sv
verilog/kbd_keymap.sv
verilog/kbd_event_fifo.sv
verilog/kbd_ctrl.sv
testbench/kbd_matrix_model.sv
testbench/tb_kbd_ctrl.sv

//--- testbench/tb_kbd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module tb_kbd_ctrl;

  import kbd_code_pkg::*;

  localparam int scan_period    = 16;
  localparam int num_tests      = 12;                        // Table rows
  localparam int scan_cycles    = `KBD_ROWS * scan_period;   // One pass over all rows
  localparam int timeout_cycles = num_tests * scan_cycles * 4;
  localparam int wait_limit     = 4 * scan_cycles;

  typedef struct packed {
    logic [63:0]     keys;       // Key positions to toggle
    logic [1:0]      n_ev;       // Events this change makes
    logic [2:0][7:0] codes;      // Index 0 comes out first
    logic            pop;        // Drain the queue afterwards
    logic            pop_empty;  // Strobe queue_ren on an empty queue first
  } stim_t;

  logic       clk;
  logic       rst;
  logic [7:0] key_col_n;
  logic [7:0] key_row;
  logic [3:0] queue_len;
  logic       queue_ren;
  scancode_t  queue;
  logic [63:0] pressed;

  stim_t      stim [num_tests];
  string      test_name [num_tests];
  logic [7:0] exp_q [$];                                     // Expected queue contents
  int         errors       = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         cycle_cnt    = 0;

  kbd_ctrl #(
    .scan_period (scan_period)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .key_col_n (key_col_n),
    .key_row   (key_row),
    .queue_len (queue_len),
    .queue_ren (queue_ren),
    .queue     (queue)
  );

  kbd_matrix_model matrix_i (
    .key_row   (key_row),
    .pressed   (pressed),
    .key_col_n (key_col_n)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [63:0] key_bit(input int row, input int col);
    return 64'd1 << (row * `KBD_COLS + col);
  endfunction

  function automatic stim_t make_entry(input logic [63:0] keys, input int n_ev,
                                       input logic [7:0] c0, input logic [7:0] c1,
                                       input logic [7:0] c2, input logic pop,
                                       input logic pop_empty);
    stim_t s;
    s.keys      = keys;
    s.n_ev      = 2'(n_ev);
    s.codes[0]  = c0;
    s.codes[1]  = c1;
    s.codes[2]  = c2;
    s.pop       = pop;
    s.pop_empty = pop_empty;
    return s;
  endfunction

  // ************************************************************
  // Stimulus table, codes from the JIS layout, bit 7 = release
  // ************************************************************
  task automatic init_table;
    test_name[0]  = "press row 2 col 1";
    stim[0]  = make_entry(key_bit(2, 1), 1, 8'h51, 8'h00, 8'h00, 1'b1, 1'b0);
    test_name[1]  = "release row 2 col 1";
    stim[1]  = make_entry(key_bit(2, 1), 1, 8'hD1, 8'h00, 8'h00, 1'b1, 1'b0);
    test_name[2]  = "press row 0 cols 1 and 3";
    stim[2]  = make_entry(key_bit(0, 1) | key_bit(0, 3), 2, 8'h31, 8'h33, 8'h00, 1'b1, 1'b0);
    test_name[3]  = "release row 0 cols 1 and 3";
    stim[3]  = make_entry(key_bit(0, 1) | key_bit(0, 3), 2, 8'hB1, 8'hB3, 8'h00, 1'b1, 1'b0);
    test_name[4]  = "queue space without pop";
    stim[4]  = make_entry(key_bit(3, 5), 1, 8'h20, 8'h00, 8'h00, 1'b0, 1'b0);
    test_name[5]  = "queue cursor right without pop";
    stim[5]  = make_entry(key_bit(7, 7), 1, 8'h1E, 8'h00, 8'h00, 1'b0, 1'b0);
    test_name[6]  = "queue 8 then drain in order";
    stim[6]  = make_entry(key_bit(1, 0), 1, 8'h38, 8'h00, 8'h00, 1'b1, 1'b0);
    test_name[7]  = "fill from row 4";
    stim[7]  = make_entry(key_bit(4, 1) | key_bit(4, 2) | key_bit(4, 3), 3,
                          8'h41, 8'h53, 8'h44, 1'b0, 1'b0);
    test_name[8]  = "fill from row 5";
    stim[8]  = make_entry(key_bit(5, 0) | key_bit(5, 1) | key_bit(5, 2), 3,
                          8'h4B, 8'h4C, 8'h3B, 1'b0, 1'b0);
    test_name[9]  = "fill row 6 past full";
    stim[9]  = make_entry(key_bit(6, 2) | key_bit(6, 3) | key_bit(6, 4), 3,
                          8'h5A, 8'h58, 8'h43, 1'b0, 1'b0);
    test_name[10] = "drop on full then drain";
    stim[10] = make_entry(key_bit(2, 2), 1, 8'h57, 8'h00, 8'h00, 1'b1, 1'b0);
    test_name[11] = "pop while empty then press";
    stim[11] = make_entry(key_bit(0, 5), 1, 8'h35, 8'h00, 8'h00, 1'b1, 1'b1);
  endtask

  task automatic step_cycle;
    @(posedge clk);
    #2;                                                      // Drive and sample point
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_queue_len(input int target);
    int n;
    n = 0;
    while (queue_len != target && n < wait_limit) begin
      step_cycle();
      n++;
    end
    if (queue_len != target) begin
      $display("queue_len stayed at %0d and never reached %0d within %0d cycles",
               queue_len, target, wait_limit);
      errors++;
    end
  endtask

  task automatic pop_entry;
    queue_ren = 1'b1;
    step_cycle();
    queue_ren = 1'b0;
  endtask

  task automatic report_test(input int idx, input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %0d (%s) passed", idx, name);
    end else begin
      tests_failed++;
      $display("test %0d (%s) failed with %0d errors", idx, name, errors - errs_before);
    end
  endtask

  task automatic check_reset;
    int err0;
    int n;
    logic [7:0] prev_row;
    err0 = errors;
    check_value("queue_len", queue_len, 0);
    check_value("queue", queue, 0);
    check_value("key_row", key_row, 8'hFE);
    for (int r = 1; r <= 2; r++) begin
      prev_row = key_row;
      n = 0;
      while (key_row == prev_row && n < 2 * scan_period) begin
        step_cycle();
        n++;
      end
      if (key_row == prev_row) begin
        $display("key_row did not move on within %0d cycles", 2 * scan_period);
        errors++;
      end
      check_value("key_row", key_row, 8'hFF ^ (8'h01 << r));  // One row further
      check_value("key_row low bits", $countones(~key_row), 1);
    end
    report_test(0, "reset and row scan", err0);
  endtask

  task automatic run_entry(input int i);
    stim_t s;
    int    err0;
    s    = stim[i];
    err0 = errors;
    if (s.pop_empty) begin
      pop_entry();
      check_value("queue_len", queue_len, 0);
      check_value("queue", queue, 0);
    end
    pressed = pressed ^ s.keys;
    for (int k = 0; k < s.n_ev; k++) begin
      if (exp_q.size() < `KBD_QUEUE_DEPTH) begin
        exp_q.push_back(s.codes[k]);                         // Full queue drops it
      end
    end
    wait_queue_len(exp_q.size());
    repeat (scan_cycles + 8) step_cycle();                   // Late or dropped events pass
    check_value("queue_len", queue_len, exp_q.size());
    if (s.pop) begin
      while (exp_q.size() > 0) begin
        check_value("queue", queue, exp_q[0]);
        pop_entry();
        void'(exp_q.pop_front());
        check_value("queue_len", queue_len, exp_q.size());
      end
      check_value("queue", queue, 0);                        // Empty head reads zero
    end
    report_test(i + 1, test_name[i], err0);
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************
  initial begin
    rst       = 1'b1;
    queue_ren = 1'b0;
    pressed   = '0;
    init_table();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    check_reset();
    for (int i = 0; i < num_tests; i++) begin
      run_entry(i);
    end
    $display("Results: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/kbd_matrix_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_matrix_model (
  input  logic [`KBD_ROWS-1:0]           key_row,    // Low bit marks the driven row
  input  logic [`KBD_ROWS*`KBD_COLS-1:0] pressed,    // Bit row*COLS+col, 1 = held
  output logic [`KBD_COLS-1:0]           key_col_n   // Pulled low by held keys
);

  // ************************************************************
  // Switch array with pull-ups on the column lines
  // ************************************************************
  always_comb begin
    key_col_n = '1;                                  // Idle high
    for (int r = 0; r < `KBD_ROWS; r++) begin
      for (int c = 0; c < `KBD_COLS; c++) begin
        if (!key_row[r] && pressed[r * `KBD_COLS + c]) begin
          key_col_n[c] = 1'b0;                       // Closed switch shorts to row
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/kbd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_ctrl #(
  parameter int scan_period = `KBD_SCAN_PERIOD
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`KBD_COLS-1:0]    key_col_n,   // Column sense, low = pressed
  output logic [`KBD_ROWS-1:0]    key_row,     // Open-drain row drive
  output logic [3:0]              queue_len,
  input  logic                    queue_ren,   // One-cycle pop strobe
  output kbd_code_pkg::scancode_t queue
);

  import kbd_scan_pkg::*;
  import kbd_code_pkg::*;

  scan_sample_t sample;
  key_event_t   key_event;
  logic         code_valid;
  scancode_t    code;

  // ************************************************************
  // Scan, detect, map, queue
  // ************************************************************
  kbd_row_scan #(
    .scan_period (scan_period)
  ) row_scan_i (
    .clk       (clk),
    .rst       (rst),
    .key_col_n (key_col_n),
    .key_row   (key_row),
    .sample    (sample)
  );

  kbd_change_detect change_detect_i (
    .clk       (clk),
    .rst       (rst),
    .sample    (sample),
    .key_event (key_event)
  );

  kbd_keymap keymap_i (
    .clk        (clk),
    .rst        (rst),
    .key_event  (key_event),
    .code_valid (code_valid),
    .code       (code)
  );

  // Host side
  kbd_event_fifo event_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .code_valid (code_valid),
    .code       (code),
    .queue_ren  (queue_ren),
    .queue_len  (queue_len),
    .queue      (queue)
  );

endmodule

`default_nettype wire

//--- verilog/kbd_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_event_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    code_valid,
  input  kbd_code_pkg::scancode_t code,
  input  logic                    queue_ren,
  output logic [3:0]              queue_len,
  output kbd_code_pkg::scancode_t queue
);

  import kbd_code_pkg::*;

  localparam int depth = `KBD_QUEUE_DEPTH;
  localparam int ptr_w = $clog2(depth);

  scancode_t        mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [3:0]       count;      // Entries held, 0 to depth
  logic             full;
  logic             empty;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == 4'(depth));
  assign empty = (count == '0);
  assign do_wr = code_valid & ~full;    // Dropped when full
  assign do_rd = queue_ren & ~empty;    // Ignored when empty

  // ************************************************************
  // Pointers and occupancy
  // ************************************************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;        // Wraps at depth
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Push and pop cancel
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= code;
    end
  end

  assign queue_len = count;
  assign queue     = empty ? '0 : mem[rd_ptr];  // Head entry

endmodule

`default_nettype wire

//--- verilog/kbd_keymap.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_keymap (
  input  logic                     clk,
  input  logic                     rst,
  input  kbd_scan_pkg::key_event_t key_event,
  output logic                     code_valid,
  output kbd_code_pkg::scancode_t  code
);

  import kbd_code_pkg::*;

  logic      valid_q;
  scancode_t code_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= key_event.valid;
    end
  end

  // Layout lookup, release flag lands in bit 7
  always_ff @(posedge clk) begin
    if (key_event.valid) begin
      code_q <= '{released: key_event.released,
                  code:     keymap_lookup(key_event.row, key_event.col)};
    end
  end

  assign code_valid = valid_q;
  assign code       = code_q;

endmodule

`default_nettype wire

//--- verilog/kbd_change_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_change_detect (
  input  logic                       clk,
  input  logic                       rst,
  input  kbd_scan_pkg::scan_sample_t sample,
  output kbd_scan_pkg::key_event_t   key_event
);

  import kbd_scan_pkg::*;

  logic [`KBD_COLS-1:0] key_state [`KBD_ROWS];  // 1 = key held down
  logic [`KBD_COLS-1:0] diff;
  logic                 diff_any;
  col_idx_t             diff_col;                // Lowest changed column
  logic                 ev_valid;
  row_idx_t             ev_row;
  col_idx_t             ev_col;
  logic                 ev_released;

  assign diff     = key_state[sample.row] ^ sample.pressed;
  assign diff_any = |diff;

  // Scan from the top so the lowest set bit wins
  always_comb begin
    diff_col = '0;
    for (int c = `KBD_COLS - 1; c >= 0; c--) begin
      if (diff[c]) begin
        diff_col = col_idx_t'(c);
      end
    end
  end

  // ************************************************************
  // Bitmap update, one key per sample
  // ************************************************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int r = 0; r < `KBD_ROWS; r++) begin
        key_state[r] <= '0;                      // All released
      end
      ev_valid <= 1'b0;
    end else begin
      ev_valid <= sample.valid & diff_any;
      // Other changed keys in the row wait for the next scan
      if (sample.valid && diff_any) begin
        key_state[sample.row][diff_col] <= sample.pressed[diff_col];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample.valid) begin
      ev_row      <= sample.row;
      ev_col      <= diff_col;
      ev_released <= ~sample.pressed[diff_col];  // New state was up
    end
  end

  assign key_event = '{valid: ev_valid, row: ev_row, col: ev_col, released: ev_released};

endmodule

`default_nettype wire

//--- verilog/kbd_row_scan.sv
`timescale 1ns/1ps
`default_nettype none

`include "kbd_consts.svh"

module kbd_row_scan #(
  parameter int scan_period = `KBD_SCAN_PERIOD  // Even, 4 or more
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`KBD_COLS-1:0]       key_col_n,
  output logic [`KBD_ROWS-1:0]       key_row,
  output kbd_scan_pkg::scan_sample_t sample
);

  import kbd_scan_pkg::*;

  localparam int cnt_w = $clog2(scan_period);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(scan_period - 1);
  localparam logic [cnt_w-1:0] cnt_mid = cnt_w'(scan_period / 2);
  localparam logic [`KBD_ROWS-1:0] row_one = 1;

  logic [cnt_w-1:0]     scan_cnt;     // Position within one row period
  row_idx_t             row_idx;      // Row being driven
  logic                 smp_valid;
  row_idx_t             smp_row;
  logic [`KBD_COLS-1:0] smp_pressed;

  // Open-drain drive, only the active row pulls low
  assign key_row = ~(row_one << row_idx);

  // ************************************************************
  // Period counter and row index
  // ************************************************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scan_cnt  <= '0;
      row_idx   <= '0;
      smp_valid <= 1'b0;
    end else begin
      smp_valid <= (scan_cnt == cnt_mid);    // Mid-period strobe
      if (scan_cnt == cnt_last) begin
        scan_cnt <= '0;
        row_idx  <= row_idx + 1'b1;          // Next row on wrap
      end else begin
        scan_cnt <= scan_cnt + 1'b1;
      end
    end
  end

  // Columns have settled by mid-period
  always_ff @(posedge clk) begin
    if (scan_cnt == cnt_mid) begin
      smp_row     <= row_idx;
      smp_pressed <= ~key_col_n;             // Active-low sense lines
    end
  end

  assign sample = '{valid: smp_valid, row: smp_row, pressed: smp_pressed};

endmodule

`default_nettype wire

//--- verilog/kbd_code_pkg.sv
`default_nettype none

// Types seen by the host, plus the key layout
package kbd_code_pkg;

  typedef logic [6:0] char_code_t;  // 7-bit ASCII-style code

  typedef struct packed {
    logic       released;  // Bit 7, set on key release
    char_code_t code;
  } scancode_t;

  // ************************************************************
  // JIS layout, indexed as {row, col} in octal
  // ************************************************************
  function automatic char_code_t keymap_lookup(
    input kbd_scan_pkg::row_idx_t row,
    input kbd_scan_pkg::col_idx_t col
  );
    case ({row, col})
      6'o00: return 7'h10;  // E/J
      6'o01: return 7'h31;  // 1
      6'o02: return 7'h32;
      6'o03: return 7'h33;
      6'o04: return 7'h34;
      6'o05: return 7'h35;
      6'o06: return 7'h36;
      6'o07: return 7'h37;  // 7
      6'o10: return 7'h38;  // 8
      6'o11: return 7'h39;
      6'o12: return 7'h30;  // 0
      6'o13: return 7'h2D;  // Minus
      6'o14: return 7'h5E;  // Caret
      6'o15: return 7'h5C;  // Yen key
      6'o16: return 7'h08;  // Backspace
      6'o17: return 7'h15;  // Kana
      6'o20: return 7'h09;  // Tab
      6'o21: return 7'h51;  // Q
      6'o22: return 7'h57;
      6'o23: return 7'h45;
      6'o24: return 7'h52;
      6'o25: return 7'h54;
      6'o26: return 7'h59;
      6'o27: return 7'h55;  // U
      6'o30: return 7'h49;  // I
      6'o31: return 7'h4F;
      6'o32: return 7'h50;  // P
      6'o33: return 7'h40;  // At sign
      6'o34: return 7'h5B;  // Open bracket
      6'o35: return 7'h20;  // Space
      6'o36: return 7'h0A;  // Enter as LF
      6'o37: return 7'h13;  // Henkan
      6'o40: return 7'h0F;  // Caps lock
      6'o41: return 7'h41;  // A
      6'o42: return 7'h53;
      6'o43: return 7'h44;
      6'o44: return 7'h46;
      6'o45: return 7'h47;
      6'o46: return 7'h48;
      6'o47: return 7'h4A;  // J
      6'o50: return 7'h4B;  // K
      6'o51: return 7'h4C;  // L
      6'o52: return 7'h3B;  // Semicolon
      6'o53: return 7'h3A;  // Colon
      6'o54: return 7'h5D;  // Close bracket
      6'o55: return 7'h12;  // Alt
      6'o56: return 7'h14;  // Muhenkan
      6'o57: return 7'h1C;  // Cursor up
      6'o60: return 7'h0E;  // Shift
      6'o61: return 7'h11;  // Ctrl
      6'o62: return 7'h5A;  // Z
      6'o63: return 7'h58;
      6'o64: return 7'h43;
      6'o65: return 7'h56;
      6'o66: return 7'h42;
      6'o67: return 7'h4E;  // N
      6'o70: return 7'h4D;  // M
      6'o71: return 7'h2C;  // Comma
      6'o72: return 7'h2E;  // Period
      6'o73: return 7'h2F;  // Slash
      6'o74: return 7'h5F;  // Underscore key
      6'o75: return 7'h1F;  // Cursor left
      6'o76: return 7'h1D;  // Cursor down
      6'o77: return 7'h1E;  // Cursor right
      default: return 7'h00;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- verilog/kbd_scan_pkg.sv
`default_nettype none

`include "kbd_consts.svh"

// Types seen on the matrix side of the controller
package kbd_scan_pkg;

  typedef logic [$clog2(`KBD_ROWS)-1:0] row_idx_t;  // Active row number
  typedef logic [$clog2(`KBD_COLS)-1:0] col_idx_t;  // Column number

  // One row worth of sensed columns
  typedef struct packed {
    logic                 valid;    // Single-cycle strobe
    row_idx_t             row;      // Row that was driven
    logic [`KBD_COLS-1:0] pressed;  // 1 = key down
  } scan_sample_t;

  // One key changing state
  typedef struct packed {
    logic     valid;     // Single-cycle strobe
    row_idx_t row;
    col_idx_t col;
    logic     released;  // 0 = press, 1 = release
  } key_event_t;

endpackage

`default_nettype wire

//--- verilog/kbd_consts.svh
`ifndef KBD_CONSTS_SVH
`define KBD_CONSTS_SVH

// Key matrix size
`define KBD_ROWS 8
`define KBD_COLS 8

// Clock cycles per row, 1 ms at 27 MHz
`define KBD_SCAN_PERIOD 27000

// Host event queue entries, power of two
`define KBD_QUEUE_DEPTH 8

`endif
